// ==== rtl/lsu_l1d_pkg.sv ====
/* Shared definitions for the L1D side ports.
   Cache geometry, the physical address union, status and snoop command types. */
`default_nettype none

package lsu_l1d_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int PADDR_W    = 32;
  localparam int XLEN_W     = 32;
  localparam int LINE_W     = 128;
  localparam int LINE_B_W   = LINE_W / 8;
  localparam int SET_NUM    = 16;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = PADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_SEL_W = 2;
  localparam int BYTE_OFF_W = 2;

  typedef logic [LINE_W-1:0] line_t;
  typedef logic [XLEN_W-1:0] word_t;

  // Array lookup view
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } paddr_cache_t;

  // Word extraction view
  typedef struct packed {
    logic [PADDR_W-OFFSET_W-1:0] line_addr;
    logic [WORD_SEL_W-1:0]       word_sel;
    logic [BYTE_OFF_W-1:0]       byte_off;
  } paddr_word_t;

  typedef union packed {
    paddr_cache_t cache;
    paddr_word_t  word;
  } paddr_u;

  typedef enum logic [1:0] {
    STATUS_NONE         = 2'd0,
    STATUS_HIT          = 2'd1,
    STATUS_MISS         = 2'd2,
    STATUS_L1D_CONFLICT = 2'd3
  } l1d_status_e;

  typedef enum logic [0:0] {
    SNOOP_READ    = 1'b0,
    SNOOP_INVALID = 1'b1
  } snoop_cmd_e;

endpackage

`default_nettype wire

// ==== rtl/l1d_array.sv ====
/* Direct-mapped L1D tag/data array.
   Two registered read ports (PTW, snoop), the read conflict rule,
   line fill and snoop invalidate writes. */
`timescale 1ns/1ps
`default_nettype none

module l1d_array (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,

  input  wire logic                i_ptw_rd_valid,
  input  lsu_l1d_pkg::paddr_u      i_ptw_rd_paddr,

  input  wire logic                i_snp_rd_valid,
  input  wire logic                i_snp_inv_valid,
  input  lsu_l1d_pkg::paddr_u      i_snp_paddr,

  input  wire logic                i_fill_valid,
  input  lsu_l1d_pkg::paddr_u      i_fill_paddr,
  input  lsu_l1d_pkg::line_t       i_fill_data,

  output logic                     o_ptw_s1_hit,
  output logic                     o_ptw_s1_miss,
  output logic                     o_ptw_s1_conflict,
  output lsu_l1d_pkg::line_t       o_ptw_s1_data,

  output logic                     o_snp_s1_hit,
  output logic                     o_snp_s1_miss,
  output lsu_l1d_pkg::line_t       o_snp_s1_data
);

  logic [lsu_l1d_pkg::SET_NUM-1:0] r_valid;
  logic [lsu_l1d_pkg::TAG_W-1:0]   r_tag  [lsu_l1d_pkg::SET_NUM];
  lsu_l1d_pkg::line_t              r_data [lsu_l1d_pkg::SET_NUM];

  logic w_ptw_match;
  logic w_snp_match;
  logic w_conflict;

  // --------------------------------------------------------------------------
  // s0 lookup against the contents before this edge's writes
  // --------------------------------------------------------------------------
  assign w_ptw_match = r_valid[i_ptw_rd_paddr.cache.index] &
                       (r_tag[i_ptw_rd_paddr.cache.index] == i_ptw_rd_paddr.cache.tag);
  assign w_snp_match = r_valid[i_snp_paddr.cache.index] &
                       (r_tag[i_snp_paddr.cache.index] == i_snp_paddr.cache.tag);

  // Snoop read always wins the shared read path
  assign w_conflict = i_ptw_rd_valid & i_snp_rd_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ptw_s1_hit      <= 1'b0;
      o_ptw_s1_miss     <= 1'b0;
      o_ptw_s1_conflict <= 1'b0;
      o_snp_s1_hit      <= 1'b0;
      o_snp_s1_miss     <= 1'b0;
    end else begin
      o_ptw_s1_hit      <= i_ptw_rd_valid & ~w_conflict & w_ptw_match;
      o_ptw_s1_miss     <= i_ptw_rd_valid & ~w_conflict & ~w_ptw_match;
      o_ptw_s1_conflict <= w_conflict;
      o_snp_s1_hit      <= i_snp_rd_valid & w_snp_match;
      o_snp_s1_miss     <= i_snp_rd_valid & ~w_snp_match;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ptw_rd_valid) begin
      o_ptw_s1_data <= r_data[i_ptw_rd_paddr.cache.index];
    end
    if (i_snp_rd_valid) begin
      o_snp_s1_data <= r_data[i_snp_paddr.cache.index];
    end
  end

  // --------------------------------------------------------------------------
  // Writes
  // --------------------------------------------------------------------------
  // Invalidate is assigned last so it wins on a shared index
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      if (i_fill_valid) begin
        r_valid[i_fill_paddr.cache.index] <= 1'b1;
      end
      if (i_snp_inv_valid) begin
        r_valid[i_snp_paddr.cache.index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_tag[i_fill_paddr.cache.index]  <= i_fill_paddr.cache.tag;
      r_data[i_fill_paddr.cache.index] <= i_fill_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/l1d_ptw_port.sv ====
/* PTW access port into the L1D array.
   Forwards the s0 read, selects the requested word in s1 and forms the status. */
`timescale 1ns/1ps
`default_nettype none

module l1d_ptw_port (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,

  input  wire logic                i_req_valid,
  input  lsu_l1d_pkg::paddr_u      i_paddr,

  input  wire logic                i_s1_hit,
  input  wire logic                i_s1_miss,
  input  wire logic                i_s1_conflict,
  input  lsu_l1d_pkg::line_t       i_s1_data,

  output logic                     o_rd_valid,
  output lsu_l1d_pkg::paddr_u      o_rd_paddr,
  output logic                     o_resp_valid,
  output lsu_l1d_pkg::l1d_status_e o_status,
  output lsu_l1d_pkg::word_t       o_data
);

  logic [lsu_l1d_pkg::WORD_SEL_W-1:0] r_word_sel;

  assign o_rd_valid = i_req_valid;
  assign o_rd_paddr = i_paddr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_resp_valid <= 1'b0;
    end else begin
      o_resp_valid <= i_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      r_word_sel <= i_paddr.word.word_sel;
    end
  end

  assign o_data = i_s1_data[r_word_sel*lsu_l1d_pkg::XLEN_W +: lsu_l1d_pkg::XLEN_W];

  assign o_status = i_s1_conflict ? lsu_l1d_pkg::STATUS_L1D_CONFLICT :
                    i_s1_hit      ? lsu_l1d_pkg::STATUS_HIT :
                    i_s1_miss     ? lsu_l1d_pkg::STATUS_MISS :
                                    lsu_l1d_pkg::STATUS_NONE;

endmodule

`default_nettype wire

// ==== rtl/l1d_snoop_port.sv ====
/* Coherence snoop port into the L1D array.
   Splits a command into line read or invalidate and builds the s1 response. */
`timescale 1ns/1ps
`default_nettype none

module l1d_snoop_port (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,

  input  wire logic                         i_req_valid,
  input  lsu_l1d_pkg::snoop_cmd_e           i_cmd,
  input  lsu_l1d_pkg::paddr_u               i_paddr,

  input  wire logic                         i_s1_hit,
  input  wire logic                         i_s1_miss,
  input  lsu_l1d_pkg::line_t                i_s1_data,

  output logic                              o_rd_valid,
  output logic                              o_inv_valid,
  output lsu_l1d_pkg::paddr_u               o_paddr,

  output logic                              o_resp_valid,
  output lsu_l1d_pkg::l1d_status_e          o_status,
  output logic [lsu_l1d_pkg::LINE_B_W-1:0]  o_be,
  output lsu_l1d_pkg::line_t                o_data
);

  // --------------------------------------------------------------------------
  // s0 command decode
  // --------------------------------------------------------------------------
  assign o_rd_valid  = i_req_valid & (i_cmd == lsu_l1d_pkg::SNOOP_READ);
  assign o_inv_valid = i_req_valid & (i_cmd == lsu_l1d_pkg::SNOOP_INVALID);
  assign o_paddr     = i_paddr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_resp_valid <= 1'b0;
    end else begin
      o_resp_valid <= i_req_valid;
    end
  end

  // --------------------------------------------------------------------------
  // s1 response
  // --------------------------------------------------------------------------
  // An invalidate leaves both flags low, giving NONE with no data
  assign o_status = i_s1_hit  ? lsu_l1d_pkg::STATUS_HIT :
                    i_s1_miss ? lsu_l1d_pkg::STATUS_MISS :
                                lsu_l1d_pkg::STATUS_NONE;

  assign o_be   = {lsu_l1d_pkg::LINE_B_W{i_s1_hit}};
  assign o_data = i_s1_hit ? i_s1_data : '0;

endmodule

`default_nettype wire

// ==== rtl/lsu_l1d_side_top.sv ====
/* L1D side access top.
   PTW port and snoop port sharing one direct-mapped tag/data array. */
`timescale 1ns/1ps
`default_nettype none

module lsu_l1d_side_top (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,

  // PTW request / response
  input  wire logic                         i_ptw_req_valid,
  input  lsu_l1d_pkg::paddr_u               i_ptw_paddr,
  output logic                              o_ptw_resp_valid,
  output lsu_l1d_pkg::l1d_status_e          o_ptw_status,
  output lsu_l1d_pkg::word_t                o_ptw_data,

  // Snoop request / response
  input  wire logic                         i_snoop_req_valid,
  input  lsu_l1d_pkg::snoop_cmd_e           i_snoop_cmd,
  input  lsu_l1d_pkg::paddr_u               i_snoop_paddr,
  output logic                              o_snoop_resp_valid,
  output lsu_l1d_pkg::l1d_status_e          o_snoop_status,
  output logic [lsu_l1d_pkg::LINE_B_W-1:0]  o_snoop_be,
  output lsu_l1d_pkg::line_t                o_snoop_data,

  // Line fill from the miss side
  input  wire logic                         i_fill_valid,
  input  lsu_l1d_pkg::paddr_u               i_fill_paddr,
  input  lsu_l1d_pkg::line_t                i_fill_data
);

  logic                ptw_rd_valid;
  lsu_l1d_pkg::paddr_u ptw_rd_paddr;
  logic                snp_rd_valid;
  logic                snp_inv_valid;
  lsu_l1d_pkg::paddr_u snp_paddr;

  logic                ptw_s1_hit;
  logic                ptw_s1_miss;
  logic                ptw_s1_conflict;
  lsu_l1d_pkg::line_t  ptw_s1_data;
  logic                snp_s1_hit;
  logic                snp_s1_miss;
  lsu_l1d_pkg::line_t  snp_s1_data;

  l1d_ptw_port u_ptw_port (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_ptw_req_valid),
    .i_paddr       (i_ptw_paddr),
    .i_s1_hit      (ptw_s1_hit),
    .i_s1_miss     (ptw_s1_miss),
    .i_s1_conflict (ptw_s1_conflict),
    .i_s1_data     (ptw_s1_data),
    .o_rd_valid    (ptw_rd_valid),
    .o_rd_paddr    (ptw_rd_paddr),
    .o_resp_valid  (o_ptw_resp_valid),
    .o_status      (o_ptw_status),
    .o_data        (o_ptw_data)
  );

  l1d_snoop_port u_snoop_port (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req_valid  (i_snoop_req_valid),
    .i_cmd        (i_snoop_cmd),
    .i_paddr      (i_snoop_paddr),
    .i_s1_hit     (snp_s1_hit),
    .i_s1_miss    (snp_s1_miss),
    .i_s1_data    (snp_s1_data),
    .o_rd_valid   (snp_rd_valid),
    .o_inv_valid  (snp_inv_valid),
    .o_paddr      (snp_paddr),
    .o_resp_valid (o_snoop_resp_valid),
    .o_status     (o_snoop_status),
    .o_be         (o_snoop_be),
    .o_data       (o_snoop_data)
  );

  l1d_array u_array (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_ptw_rd_valid    (ptw_rd_valid),
    .i_ptw_rd_paddr    (ptw_rd_paddr),
    .i_snp_rd_valid    (snp_rd_valid),
    .i_snp_inv_valid   (snp_inv_valid),
    .i_snp_paddr       (snp_paddr),
    .i_fill_valid      (i_fill_valid),
    .i_fill_paddr      (i_fill_paddr),
    .i_fill_data       (i_fill_data),
    .o_ptw_s1_hit      (ptw_s1_hit),
    .o_ptw_s1_miss     (ptw_s1_miss),
    .o_ptw_s1_conflict (ptw_s1_conflict),
    .o_ptw_s1_data     (ptw_s1_data),
    .o_snp_s1_hit      (snp_s1_hit),
    .o_snp_s1_miss     (snp_s1_miss),
    .o_snp_s1_data     (snp_s1_data)
  );

endmodule

`default_nettype wire

// ==== dv/lsu_l1d_side_assertions.sv ====
/* Shadow cache model and response assertions for the L1D side top,
   with the bind into lsu_l1d_side_top. */
`timescale 1ns/1ps
`default_nettype none

module lsu_l1d_side_assertions (
  input wire logic                        i_clk,
  input wire logic                        i_reset_n,
  input wire logic                        i_ptw_req_valid,
  input lsu_l1d_pkg::paddr_u              i_ptw_paddr,
  input wire logic                        i_snoop_req_valid,
  input lsu_l1d_pkg::snoop_cmd_e          i_snoop_cmd,
  input lsu_l1d_pkg::paddr_u              i_snoop_paddr,
  input wire logic                        i_fill_valid,
  input lsu_l1d_pkg::paddr_u              i_fill_paddr,
  input lsu_l1d_pkg::line_t               i_fill_data,
  input wire logic                        o_ptw_resp_valid,
  input lsu_l1d_pkg::l1d_status_e         o_ptw_status,
  input lsu_l1d_pkg::word_t               o_ptw_data,
  input wire logic                        o_snoop_resp_valid,
  input lsu_l1d_pkg::l1d_status_e         o_snoop_status,
  input wire logic [lsu_l1d_pkg::LINE_B_W-1:0] o_snoop_be,
  input lsu_l1d_pkg::line_t               o_snoop_data
);

  int fail_count = 0;

  logic [lsu_l1d_pkg::SET_NUM-1:0] sh_valid;
  logic [lsu_l1d_pkg::TAG_W-1:0]   sh_tag  [lsu_l1d_pkg::SET_NUM];
  lsu_l1d_pkg::line_t              sh_line [lsu_l1d_pkg::SET_NUM];

  logic                            exp_ptw_vld;
  logic                            exp_snp_vld;
  lsu_l1d_pkg::l1d_status_e        exp_ptw_status;
  lsu_l1d_pkg::l1d_status_e        exp_snp_status;
  lsu_l1d_pkg::word_t              exp_ptw_data;
  lsu_l1d_pkg::line_t              exp_snp_data;
  logic [lsu_l1d_pkg::LINE_B_W-1:0] exp_snp_be;

  logic ptw_hit;
  logic snp_hit;
  logic snp_read;

  assign ptw_hit = sh_valid[i_ptw_paddr.cache.index] &&
                   (sh_tag[i_ptw_paddr.cache.index] == i_ptw_paddr.cache.tag);
  assign snp_hit = sh_valid[i_snoop_paddr.cache.index] &&
                   (sh_tag[i_snoop_paddr.cache.index] == i_snoop_paddr.cache.tag);
  assign snp_read = i_snoop_req_valid && (i_snoop_cmd == lsu_l1d_pkg::SNOOP_READ);

  // ------------------------------------------------------------------------
  // Expected s1 responses from the shadow before this edge's writes
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      sh_valid    <= '0;
      exp_ptw_vld <= 1'b0;
      exp_snp_vld <= 1'b0;
    end else begin
      exp_ptw_vld <= i_ptw_req_valid;
      exp_snp_vld <= i_snoop_req_valid;
      if (i_ptw_req_valid && snp_read) begin
        exp_ptw_status <= lsu_l1d_pkg::STATUS_L1D_CONFLICT;
      end else begin
        exp_ptw_status <= ptw_hit ? lsu_l1d_pkg::STATUS_HIT : lsu_l1d_pkg::STATUS_MISS;
      end
      exp_ptw_data <= sh_line[i_ptw_paddr.cache.index][i_ptw_paddr.word.word_sel*32 +: 32];
      if (!snp_read) begin
        exp_snp_status <= lsu_l1d_pkg::STATUS_NONE;
      end else begin
        exp_snp_status <= snp_hit ? lsu_l1d_pkg::STATUS_HIT : lsu_l1d_pkg::STATUS_MISS;
      end
      exp_snp_be   <= (snp_read && snp_hit) ? '1 : '0;
      exp_snp_data <= (snp_read && snp_hit) ? sh_line[i_snoop_paddr.cache.index] : '0;
      if (i_fill_valid) begin
        sh_valid[i_fill_paddr.cache.index] <= 1'b1;
      end
      // Invalidate wins over a fill to the same set
      if (i_snoop_req_valid && (i_snoop_cmd == lsu_l1d_pkg::SNOOP_INVALID)) begin
        sh_valid[i_snoop_paddr.cache.index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      sh_tag[i_fill_paddr.cache.index]  <= i_fill_paddr.cache.tag;
      sh_line[i_fill_paddr.cache.index] <= i_fill_data;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  a_ptw_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ptw_resp_valid == exp_ptw_vld)
    else begin
      $error("[FAIL] %0t o_ptw_resp_valid got %b exp %b", $time, o_ptw_resp_valid, exp_ptw_vld);
      fail_count++;
    end

  a_ptw_status : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ptw_resp_valid |-> o_ptw_status == exp_ptw_status)
    else begin
      $error("[FAIL] %0t o_ptw_status got %0d exp %0d", $time, o_ptw_status, exp_ptw_status);
      fail_count++;
    end

  a_ptw_data : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_ptw_resp_valid && exp_ptw_status == lsu_l1d_pkg::STATUS_HIT) |->
    o_ptw_data == exp_ptw_data)
    else begin
      $error("[FAIL] %0t o_ptw_data got %h exp %h", $time, o_ptw_data, exp_ptw_data);
      fail_count++;
    end

  a_snp_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_resp_valid == exp_snp_vld)
    else begin
      $error("[FAIL] %0t o_snoop_resp_valid got %b exp %b", $time, o_snoop_resp_valid,
             exp_snp_vld);
      fail_count++;
    end

  a_snp_status : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_resp_valid |-> o_snoop_status == exp_snp_status)
    else begin
      $error("[FAIL] %0t o_snoop_status got %0d exp %0d", $time, o_snoop_status,
             exp_snp_status);
      fail_count++;
    end

  a_snp_be : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_resp_valid |-> o_snoop_be == exp_snp_be)
    else begin
      $error("[FAIL] %0t o_snoop_be got %h exp %h", $time, o_snoop_be, exp_snp_be);
      fail_count++;
    end

  a_snp_data : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_resp_valid |-> o_snoop_data == exp_snp_data)
    else begin
      $error("[FAIL] %0t o_snoop_data got %h exp %h", $time, o_snoop_data, exp_snp_data);
      fail_count++;
    end

endmodule

bind lsu_l1d_side_top lsu_l1d_side_assertions u_assertions (.*);

`default_nettype wire

// ==== dv/tb_lsu_l1d_side.sv ====
/* Testbench for the L1D side top: clock, reset, xorshift stimulus,
   response waits with timeouts and the final verdict. */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_l1d_side;

  localparam int MAX_WAIT = 8;

  logic                             i_clk;
  logic                             i_reset_n;
  logic                             i_ptw_req_valid;
  lsu_l1d_pkg::paddr_u              i_ptw_paddr;
  logic                             o_ptw_resp_valid;
  lsu_l1d_pkg::l1d_status_e         o_ptw_status;
  lsu_l1d_pkg::word_t               o_ptw_data;
  logic                             i_snoop_req_valid;
  lsu_l1d_pkg::snoop_cmd_e          i_snoop_cmd;
  lsu_l1d_pkg::paddr_u              i_snoop_paddr;
  logic                             o_snoop_resp_valid;
  lsu_l1d_pkg::l1d_status_e         o_snoop_status;
  logic [lsu_l1d_pkg::LINE_B_W-1:0] o_snoop_be;
  lsu_l1d_pkg::line_t               o_snoop_data;
  logic                             i_fill_valid;
  lsu_l1d_pkg::paddr_u              i_fill_paddr;
  lsu_l1d_pkg::line_t               i_fill_data;

  logic [31:0]                      rng_state;
  logic [lsu_l1d_pkg::TAG_W-1:0]    tag_pool [4];

  lsu_l1d_side_top lsu_l1d_side_top_inst (.*);

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Tags come from a small pool so that hits and misses both occur
  task automatic draw_paddr(output lsu_l1d_pkg::paddr_u a);
    logic [31:0] r;
    draw(r);
    a = {tag_pool[r[1:0]], r[5:2], r[9:6]};
  endtask

  task automatic draw_line(output lsu_l1d_pkg::line_t d);
    logic [31:0] r0, r1, r2, r3;
    draw(r0);
    draw(r1);
    draw(r2);
    draw(r3);
    d = {r0, r1, r2, r3};
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s at %0t", what, $time);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic wait_responses(input logic want_ptw, input logic want_snp);
    logic seen_ptw;
    logic seen_snp;
    seen_ptw = !want_ptw;
    seen_snp = !want_snp;
    for (int n = 0; n < MAX_WAIT && !(seen_ptw && seen_snp); n++) begin
      @(negedge i_clk);
      seen_ptw = seen_ptw | o_ptw_resp_valid;
      seen_snp = seen_snp | o_snoop_resp_valid;
    end
    if (!seen_ptw) timeout_fail("the PTW response");
    if (!seen_snp) timeout_fail("the snoop response");
  endtask

  // One s0 cycle with any mix of PTW read, snoop command and fill
  task automatic issue(input logic ptw, input logic snp, input lsu_l1d_pkg::snoop_cmd_e cmd,
                       input lsu_l1d_pkg::paddr_u ptw_a, input lsu_l1d_pkg::paddr_u snp_a,
                       input logic fill, input lsu_l1d_pkg::paddr_u fill_a,
                       input lsu_l1d_pkg::line_t fill_d);
    @(posedge i_clk);
    i_ptw_req_valid   <= ptw;
    i_ptw_paddr       <= ptw_a;
    i_snoop_req_valid <= snp;
    i_snoop_cmd       <= cmd;
    i_snoop_paddr     <= snp_a;
    i_fill_valid      <= fill;
    i_fill_paddr      <= fill_a;
    i_fill_data       <= fill_d;
    @(posedge i_clk);
    i_ptw_req_valid   <= 1'b0;
    i_snoop_req_valid <= 1'b0;
    i_fill_valid      <= 1'b0;
    if (ptw || snp) wait_responses(ptw, snp);
  endtask

  task automatic drain;
    int n;
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while ((o_ptw_resp_valid || o_snoop_resp_valid) && n < MAX_WAIT);
    if (o_ptw_resp_valid || o_snoop_resp_valid) timeout_fail("the responses to drain");
  endtask

  always @(posedge i_clk) begin
    if (lsu_l1d_side_top_inst.u_assertions.fail_count != 0) begin
      $display("An assertion on the DUT responses failed at %0t", $time);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin
    #200us;
    $display("Simulation did not finish in time");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    lsu_l1d_pkg::paddr_u a;
    lsu_l1d_pkg::paddr_u b;
    lsu_l1d_pkg::line_t  d;
    logic [31:0]         r;

    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_ptw_req_valid   = 1'b0;
    i_ptw_paddr       = '0;
    i_snoop_req_valid = 1'b0;
    i_snoop_cmd       = lsu_l1d_pkg::SNOOP_READ;
    i_snoop_paddr     = '0;
    i_fill_valid      = 1'b0;
    i_fill_paddr      = '0;
    i_fill_data       = '0;
    rng_state         = 32'h0a47_e3eb;
    for (int i = 0; i < 4; i++) begin
      draw(r);
      tag_pool[i] = r[lsu_l1d_pkg::TAG_W-1:0];
    end
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    repeat (2) @(posedge i_clk);

    // Reads before any fill
    draw_paddr(a);
    draw_paddr(b);
    issue(1'b1, 1'b0, lsu_l1d_pkg::SNOOP_READ, a, b, 1'b0, a, '0);
    issue(1'b0, 1'b1, lsu_l1d_pkg::SNOOP_READ, a, b, 1'b0, a, '0);

    // Fill, then hit and tag-miss reads on both ports
    for (int i = 0; i < 24; i++) begin
      draw_paddr(a);
      draw_line(d);
      issue(1'b0, 1'b0, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b1, a, d);
      issue(1'b1, 1'b0, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b0, a, d);
      issue(1'b0, 1'b1, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b0, a, d);
      b = a;
      b.cache.tag = ~a.cache.tag;
      issue(1'b1, 1'b0, lsu_l1d_pkg::SNOOP_READ, b, b, 1'b0, a, d);
    end

    // Invalidate, then reads miss until refilled
    issue(1'b0, 1'b1, lsu_l1d_pkg::SNOOP_INVALID, a, a, 1'b0, a, d);
    issue(1'b1, 1'b1, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b0, a, d);
    issue(1'b1, 1'b0, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b0, a, d);

    // Fill and invalidate on one set in one cycle
    draw_line(d);
    issue(1'b0, 1'b1, lsu_l1d_pkg::SNOOP_INVALID, a, a, 1'b1, a, d);
    issue(1'b1, 1'b0, lsu_l1d_pkg::SNOOP_READ, a, a, 1'b0, a, d);

    // Back-to-back random traffic with conflicts and overlapping writes
    for (int i = 0; i < 300; i++) begin
      draw(r);
      draw_paddr(a);
      draw_paddr(b);
      draw_line(d);
      @(posedge i_clk);
      i_ptw_req_valid   <= r[0];
      i_ptw_paddr       <= a;
      i_snoop_req_valid <= r[1];
      i_snoop_cmd       <= (r[3:2] == 2'b00) ? lsu_l1d_pkg::SNOOP_INVALID
                                             : lsu_l1d_pkg::SNOOP_READ;
      i_snoop_paddr     <= r[7] ? a : b;
      i_fill_valid      <= (r[6:4] < 3'd3);
      i_fill_paddr      <= r[8] ? b : a;
      i_fill_data       <= d;
    end
    @(posedge i_clk);
    i_ptw_req_valid   <= 1'b0;
    i_snoop_req_valid <= 1'b0;
    i_fill_valid      <= 1'b0;
    drain();
    repeat (2) @(posedge i_clk);

    if (lsu_l1d_side_top_inst.u_assertions.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/lsu_l1d_pkg.sv
rtl/l1d_array.sv
rtl/l1d_ptw_port.sv
rtl/l1d_snoop_port.sv
rtl/lsu_l1d_side_top.sv
dv/lsu_l1d_side_assertions.sv
dv/tb_lsu_l1d_side.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_lsu_l1d_side
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
